// File: source/dsiq_defines.svh
`ifndef DSIQ_DEFINES_SVH
`define DSIQ_DEFINES_SVH

// store depth in 32-bit words
`define DSIQ_DEPTH 64

// word count holds 0..DSIQ_DEPTH
`define DSIQ_CNT_W 7

// push and pop hysteresis threshold
`define DSIQ_HALF 32

// count to 7-bit status level
`define DSIQ_LEVEL_SHIFT 0

`endif

// File: source/dsiq_stream_pkg.sv
package dsiq_stream_pkg;

  // one beat from the byte-wide write stream
  typedef struct packed {
    logic [7:0] data;
    logic       last;
  } byte_beat_t;

  // one packed IQ word, first byte of the group in the top lane
  typedef struct packed {
    logic [31:0] data;
  } word_beat_t;

  localparam int BYTE_BEAT_W = $bits(byte_beat_t);
  localparam int WORD_BEAT_W = $bits(word_beat_t);

endpackage

// File: source/dsiq_status_pkg.sv
`include "dsiq_defines.svh"

package dsiq_status_pkg;

  // store occupancy as seen from the control side
  typedef struct packed {
    logic [`DSIQ_CNT_W-1:0] count;
    logic                   full;
    logic                   empty;
  } fill_t;

  // sampled status word, recovery bit on top
  typedef struct packed {
    logic       recovery;
    logic [6:0] level;
  } status_t;

endpackage

// File: source/dsiq_byte_packer.sv
`timescale 1ns/1ps

module dsiq_byte_packer (
  input  logic                         rd_clk,
  input  logic                         rst,
  input  logic                         byte_take,
  input  dsiq_stream_pkg::byte_beat_t  byte_in,
  input  logic                         push_block,
  output logic                         word_push,
  output dsiq_stream_pkg::word_beat_t  word_out
);

  logic [1:0] lane;
  logic [7:0] held [0:2];
  logic       last_lane;

  assign last_lane = (lane == 2'd3);

  // lane counter wraps back to zero on the fourth byte
  always_ff @(posedge rd_clk) begin
    if (rst) begin
      lane <= 2'd0;
    end else if (byte_take) begin
      lane <= lane + 2'd1;
    end
  end

  // first three bytes of a group wait here
  always_ff @(posedge rd_clk) begin
    if (byte_take && !last_lane) begin
      held[lane] <= byte_in.data;
    end
  end

  // fourth byte joins combinationally, big-endian
  assign word_push     = byte_take && last_lane;
  assign word_out.data = {held[0], held[1], held[2], byte_in.data};

  // packets are whole words, so last only lands in lane three
  a_last_aligned: assert property (
    @(posedge rd_clk) disable iff (rst)
    (byte_take && byte_in.last) |-> last_lane
  ) else $error("wr_tlast accepted in lane %0d", lane);

  // push blocking may only start on a word boundary
  a_block_aligned: assert property (
    @(posedge rd_clk) disable iff (rst)
    push_block |-> (lane == 2'd0)
  ) else $error("push blocked with %0d bytes held", lane);

endmodule

// File: source/dsiq_word_store.sv
`timescale 1ns/1ps

`include "dsiq_defines.svh"

module dsiq_word_store (
  input  logic                         rd_clk,
  input  logic                         rst,
  input  logic                         word_push,
  input  dsiq_stream_pkg::word_beat_t  word_in,
  input  logic                         word_pop,
  output dsiq_stream_pkg::word_beat_t  head,
  output dsiq_status_pkg::fill_t       fill
);

  localparam int PTR_W = $clog2(`DSIQ_DEPTH);
  localparam int CNT_W = `DSIQ_CNT_W;
  localparam logic [CNT_W-1:0] FULL_CNT = CNT_W'(`DSIQ_DEPTH);

  dsiq_stream_pkg::word_beat_t mem [`DSIQ_DEPTH];

  logic [PTR_W-1:0] wr_ptr;
  logic [PTR_W-1:0] rd_ptr;
  logic [CNT_W-1:0] count;
  logic             full;
  logic             empty;

  assign full  = (count == FULL_CNT);
  assign empty = (count == '0);

  always_ff @(posedge rd_clk) begin
    if (word_push) begin
      mem[wr_ptr] <= word_in;
    end
  end

  // pointers wrap naturally at the power-of-two depth
  always_ff @(posedge rd_clk) begin
    if (rst) begin
      wr_ptr <= '0;
      rd_ptr <= '0;
    end else begin
      if (word_push) begin
        wr_ptr <= wr_ptr + 1'b1;
      end
      if (word_pop) begin
        rd_ptr <= rd_ptr + 1'b1;
      end
    end
  end

  always_ff @(posedge rd_clk) begin
    if (rst) begin
      count <= '0;
    end else begin
      case ({word_push, word_pop})
        2'b10:   count <= count + 1'b1;
        2'b01:   count <= count - 1'b1;
        default: count <= count;
      endcase
    end
  end

  // show-ahead head word
  assign head = mem[rd_ptr];

  assign fill = '{count: count, full: full, empty: empty};

  a_no_overflow: assert property (
    @(posedge rd_clk) disable iff (rst)
    word_push |-> !full
  ) else $error("word pushed into full store");

  a_no_underflow: assert property (
    @(posedge rd_clk) disable iff (rst)
    word_pop |-> !empty
  ) else $error("word popped from empty store");

endmodule

// File: source/dsiq_flow_ctrl.sv
`timescale 1ns/1ps

`include "dsiq_defines.svh"

module dsiq_flow_ctrl (
  input  logic                         rd_clk,
  input  logic                         rst,
  input  logic                         wr_tvalid,
  input  logic                         wr_tlast,
  output logic                         wr_tready,
  output logic                         byte_take,
  output logic                         push_block,
  input  dsiq_status_pkg::fill_t       fill,
  input  dsiq_stream_pkg::word_beat_t  head,
  input  logic                         rd_tready,
  output logic                         rd_tvalid,
  output logic [31:0]                  rd_tdata,
  output logic                         word_pop,
  input  logic                         rd_sample,
  output dsiq_status_pkg::status_t     rd_status
);

  localparam int CNT_W = `DSIQ_CNT_W;
  localparam logic [CNT_W-1:0] HALF_CNT = CNT_W'(`DSIQ_HALF);

  logic push_en;
  logic pop_en;
  logic live_flag;

  dsiq_status_pkg::status_t status_q;

  // once full, hold off writes until a packet ends at half or below
  always_ff @(posedge rd_clk) begin
    if (rst) begin
      push_en <= 1'b1;
    end else if (fill.full) begin
      push_en <= 1'b0;
    end else if (wr_tvalid && wr_tlast && (fill.count <= HALF_CNT)) begin
      push_en <= 1'b1;
    end
  end

  // once empty, hold off reads until half full again
  always_ff @(posedge rd_clk) begin
    if (rst) begin
      pop_en <= 1'b0;
    end else if (fill.empty) begin
      pop_en <= 1'b0;
    end else if (fill.count >= HALF_CNT) begin
      pop_en <= 1'b1;
    end
  end

  assign wr_tready  = push_en && !fill.full;
  assign byte_take  = wr_tvalid && wr_tready;
  // high on the cycle whose edge drops push_en
  assign push_block = push_en && fill.full;

  assign rd_tvalid = pop_en && !fill.empty;
  assign rd_tdata  = pop_en ? head.data : 32'h0;
  assign word_pop  = rd_tvalid && rd_tready;

  // reported flag describes the interval before the last sample
  always_ff @(posedge rd_clk) begin
    if (rst) begin
      live_flag <= 1'b0;
      status_q  <= '0;
    end else if (rd_sample) begin
      status_q.level    <= 7'(fill.count >> `DSIQ_LEVEL_SHIFT);
      status_q.recovery <= live_flag;
      live_flag         <= 1'b0;
    end else if (!push_en || !pop_en) begin
      live_flag <= 1'b1;
    end
  end

  assign rd_status = status_q;

  // the word count must agree that something is stored
  a_valid_not_empty: assert property (
    @(posedge rd_clk) disable iff (rst)
    rd_tvalid |-> (fill.count != '0)
  ) else $error("rd_tvalid high on empty store");

  // a stalled word stays offered and unchanged
  a_stall_holds: assert property (
    @(posedge rd_clk) disable iff (rst)
    (rd_tvalid && !rd_tready) |=> (rd_tvalid && $stable(rd_tdata))
  ) else $error("stalled read word changed");

endmodule

// File: source/dsiq_buffer.sv
`timescale 1ns/1ps

module dsiq_buffer (
  input  logic                      rd_clk,
  input  logic                      rst,
  input  logic [7:0]                wr_tdata,
  input  logic                      wr_tvalid,
  input  logic                      wr_tlast,
  output logic                      wr_tready,
  output logic [31:0]               rd_tdata,
  output logic                      rd_tvalid,
  input  logic                      rd_tready,
  input  logic                      rd_sample,
  output dsiq_status_pkg::status_t  rd_status
);

  dsiq_stream_pkg::byte_beat_t wr_beat;
  dsiq_stream_pkg::word_beat_t packed_word;
  dsiq_stream_pkg::word_beat_t head_word;
  dsiq_status_pkg::fill_t      fill;

  logic byte_take;
  logic push_block;
  logic word_push;
  logic word_pop;

  assign wr_beat = '{data: wr_tdata, last: wr_tlast};

  dsiq_byte_packer packer_i (
    .rd_clk     (rd_clk),
    .rst        (rst),
    .byte_take  (byte_take),
    .byte_in    (wr_beat),
    .push_block (push_block),
    .word_push  (word_push),
    .word_out   (packed_word)
  );

  dsiq_word_store store_i (
    .rd_clk    (rd_clk),
    .rst       (rst),
    .word_push (word_push),
    .word_in   (packed_word),
    .word_pop  (word_pop),
    .head      (head_word),
    .fill      (fill)
  );

  dsiq_flow_ctrl ctrl_i (
    .rd_clk     (rd_clk),
    .rst        (rst),
    .wr_tvalid  (wr_tvalid),
    .wr_tlast   (wr_tlast),
    .wr_tready  (wr_tready),
    .byte_take  (byte_take),
    .push_block (push_block),
    .fill       (fill),
    .head       (head_word),
    .rd_tready  (rd_tready),
    .rd_tvalid  (rd_tvalid),
    .rd_tdata   (rd_tdata),
    .word_pop   (word_pop),
    .rd_sample  (rd_sample),
    .rd_status  (rd_status)
  );

endmodule

// File: dv/dsiq_buffer_tb.sv
`timescale 1ns/1ps

`include "dsiq_defines.svh"

module dsiq_buffer_tb;

  localparam int CNT_W = `DSIQ_CNT_W;
  // full sequence runs near 1100 cycles
  localparam int CYCLE_LIMIT = 4000;
  localparam logic [CNT_W-1:0] FULL_CNT = CNT_W'(`DSIQ_DEPTH);
  localparam logic [CNT_W-1:0] HALF_CNT = CNT_W'(`DSIQ_HALF);

  logic        rd_clk;
  logic        rst;
  logic [7:0]  wr_tdata;
  logic        wr_tvalid;
  logic        wr_tlast;
  logic        wr_tready;
  logic [31:0] rd_tdata;
  logic        rd_tvalid;
  logic        rd_tready;
  logic        rd_sample;
  dsiq_status_pkg::status_t rd_status;

  // stimulus state
  logic [1:0] tx_lane;
  int         pkt_words;
  logic       marker_on;
  int         err_count;
  int         cycle_count;

  // reference model
  logic             rst_d;
  logic [CNT_W-1:0] m_count;
  logic             m_push_en;
  logic             m_pop_en;
  logic [1:0]       m_lane;
  logic [23:0]      m_bytes;
  logic [31:0]      exp_mem [0:255];
  logic [7:0]       exp_wr;
  logic [7:0]       exp_rd;
  logic [31:0]      exp_head;
  logic             m_live;
  logic             m_rec;
  logic [6:0]       m_level;
  logic             sample_seen;
  int               sample_count;
  int               rec_set_count;
  int               rec_clear_count;
  int               release_count;
  logic             m_wr_ready;
  logic             m_rd_valid;
  logic             byte_acc;
  logic             word_done;
  logic             word_taken;

  dsiq_buffer uut (
    .rd_clk    (rd_clk),
    .rst       (rst),
    .wr_tdata  (wr_tdata),
    .wr_tvalid (wr_tvalid),
    .wr_tlast  (wr_tlast),
    .wr_tready (wr_tready),
    .rd_tdata  (rd_tdata),
    .rd_tvalid (rd_tvalid),
    .rd_tready (rd_tready),
    .rd_sample (rd_sample),
    .rd_status (rd_status)
  );

  always #10 rd_clk = ~rd_clk;

  assign m_wr_ready = m_push_en && (m_count != FULL_CNT);
  assign m_rd_valid = m_pop_en && (m_count != '0);
  assign byte_acc   = wr_tvalid && m_wr_ready;
  assign word_done  = byte_acc && (m_lane == 2'd3);
  assign word_taken = m_rd_valid && rd_tready;
  assign exp_head   = exp_mem[exp_rd];

  always_ff @(posedge rd_clk) begin
    rst_d <= rst;
    if (rst) begin
      m_count         <= '0;
      m_push_en       <= 1'b1;
      m_pop_en        <= 1'b0;
      m_lane          <= 2'd0;
      m_bytes         <= '0;
      exp_wr          <= '0;
      exp_rd          <= '0;
      m_live          <= 1'b0;
      m_rec           <= 1'b0;
      m_level         <= '0;
      sample_seen     <= 1'b0;
      sample_count    <= 0;
      rec_set_count   <= 0;
      rec_clear_count <= 0;
      release_count   <= 0;
    end else begin
      if (byte_acc) begin
        m_lane  <= m_lane + 2'd1;
        m_bytes <= {m_bytes[15:0], wr_tdata};
      end
      // first byte of the group lands on top
      if (word_done) begin
        exp_mem[exp_wr] <= {m_bytes, wr_tdata};
        exp_wr          <= exp_wr + 8'd1;
      end
      if (word_taken) begin
        exp_rd <= exp_rd + 8'd1;
      end
      case ({word_done, word_taken})
        2'b10:   m_count <= m_count + CNT_W'(1);
        2'b01:   m_count <= m_count - CNT_W'(1);
        default: m_count <= m_count;
      endcase
      if (m_count == FULL_CNT) begin
        m_push_en <= 1'b0;
      end else if (wr_tvalid && wr_tlast && (m_count <= HALF_CNT)) begin
        m_push_en <= 1'b1;
        if (!m_push_en) begin
          release_count <= release_count + 1;
        end
      end
      if (m_count == '0) begin
        m_pop_en <= 1'b0;
      end else if (m_count >= HALF_CNT) begin
        m_pop_en <= 1'b1;
      end
      sample_seen <= rd_sample;
      if (rd_sample) begin
        m_level <= 7'(m_count);
        m_rec   <= m_live;
        m_live  <= 1'b0;
      end else if (!m_push_en || !m_pop_en) begin
        m_live <= 1'b1;
      end
      // the very first sample has no earlier interval to judge
      if (sample_seen) begin
        sample_count <= sample_count + 1;
        if (m_rec) begin
          rec_set_count <= rec_set_count + 1;
        end else if (sample_count > 0) begin
          rec_clear_count <= rec_clear_count + 1;
        end
      end
    end
  end

  a_reset_state: assert property (
    @(posedge rd_clk) (rst_d && !rst) |->
      (wr_tready && !rd_tvalid && (rd_tdata == 32'h0) && (rd_status == '0))
  ) else begin
    err_count = err_count + 1;
    $display("[FAIL] %0t: outputs not at their reset values", $time);
  end

  a_write_ready: assert property (
    @(posedge rd_clk) disable iff (rst) wr_tready == m_wr_ready
  ) else begin
    err_count = err_count + 1;
    $display("[FAIL] %0t: wr_tready %b, expected %b", $time, wr_tready, m_wr_ready);
  end

  a_read_valid: assert property (
    @(posedge rd_clk) disable iff (rst) rd_tvalid == m_rd_valid
  ) else begin
    err_count = err_count + 1;
    $display("[FAIL] %0t: rd_tvalid %b, expected %b", $time, rd_tvalid, m_rd_valid);
  end

  a_blocked_zero: assert property (
    @(posedge rd_clk) disable iff (rst) !m_pop_en |-> (rd_tdata == 32'h0)
  ) else begin
    err_count = err_count + 1;
    $display("[FAIL] %0t: rd_tdata %h while reads blocked", $time, rd_tdata);
  end

  a_data_order: assert property (
    @(posedge rd_clk) disable iff (rst) word_taken |-> (rd_tdata == exp_head)
  ) else begin
    err_count = err_count + 1;
    $display("[FAIL] %0t: popped %h, expected %h", $time, rd_tdata, exp_head);
  end

  a_status_level: assert property (
    @(posedge rd_clk) disable iff (rst) sample_seen |-> (rd_status.level == m_level)
  ) else begin
    err_count = err_count + 1;
    $display("[FAIL] %0t: level %0d, expected %0d", $time, rd_status.level, m_level);
  end

  a_status_recovery: assert property (
    @(posedge rd_clk) disable iff (rst) sample_seen |-> (rd_status.recovery == m_rec)
  ) else begin
    err_count = err_count + 1;
    $display("[FAIL] %0t: recovery %b, expected %b", $time, rd_status.recovery, m_rec);
  end

  function automatic int unsigned steady_wr_pct();
    if (int'(m_count) < `DSIQ_HALF + 4) begin
      return 90;
    end
    return 40;
  endfunction

  function automatic int unsigned steady_rd_pct();
    if (int'(m_count) > `DSIQ_HALF - 4) begin
      return 40;
    end
    return 5;
  endfunction

  // one clock of stimulus; bytes are offered only while ready is high
  task automatic drive_cycle(input int unsigned wr_pct, input int unsigned rd_pct,
                             input logic smp);
    if (marker_on) begin
      wr_tvalid = 1'b1;
      wr_tlast  = 1'b1;
      wr_tdata  = 8'h00;
    end else if (wr_tready && ($urandom_range(99, 0) < wr_pct)) begin
      wr_tvalid = 1'b1;
      wr_tdata  = 8'($urandom);
      wr_tlast  = (tx_lane == 2'd3) && (pkt_words == 1);
      if (tx_lane == 2'd3) begin
        if (pkt_words == 1) begin
          pkt_words = int'($urandom_range(3, 1));
        end else begin
          pkt_words = pkt_words - 1;
        end
      end
      tx_lane = tx_lane + 2'd1;
    end else begin
      wr_tvalid = 1'b0;
      wr_tlast  = 1'b0;
    end
    rd_tready = ($urandom_range(99, 0) < rd_pct);
    rd_sample = smp;
    @(posedge rd_clk);
    #1;
  endtask

  task automatic stream_steady(input int cycles, input logic smp_at_end);
    repeat (cycles) begin
      drive_cycle(steady_wr_pct(), steady_rd_pct(), 1'b0);
    end
    drive_cycle(steady_wr_pct(), steady_rd_pct(), smp_at_end);
  endtask

  initial begin
    void'($urandom(21847));
    rd_clk    = 1'b0;
    rst       = 1'b1;
    wr_tdata  = 8'h00;
    wr_tvalid = 1'b0;
    wr_tlast  = 1'b0;
    rd_tready = 1'b0;
    rd_sample = 1'b0;
    tx_lane   = 2'd0;
    pkt_words = 1;
    marker_on = 1'b0;
    err_count = 0;
    repeat (3) @(posedge rd_clk);
    #1;
    rst = 1'b0;

    // streaming below full, reads start at half
    drive_cycle(0, 0, 1'b1);
    while (!m_pop_en) begin
      drive_cycle(80, 0, 1'b0);
    end
    repeat (3) begin
      stream_steady(120, 1'b1);
    end

    // stalled reads until full
    while (m_count != FULL_CNT) begin
      drive_cycle(90, 0, 1'b0);
    end
    repeat (6) drive_cycle(90, 0, 1'b0);
    drive_cycle(0, 0, 1'b1);

    // packet end above half must not release writes
    marker_on = 1'b1;
    while (m_count > HALF_CNT) begin
      drive_cycle(0, 70, 1'b0);
    end
    marker_on = 1'b0;
    while (m_count != '0) begin
      drive_cycle(0, 70, 1'b0);
    end
    repeat (6) drive_cycle(0, 70, 1'b0);
    drive_cycle(0, 0, 1'b1);

    // packet end marker at low fill, withdrawn once ready returns
    marker_on = 1'b1;
    while (!wr_tready) begin
      drive_cycle(0, 0, 1'b0);
    end
    marker_on = 1'b0;
    while (!m_pop_en) begin
      drive_cycle(85, 50, 1'b0);
    end
    stream_steady(100, 1'b1);

    // final drain
    while (m_count != '0) begin
      drive_cycle(0, 70, 1'b0);
    end
    repeat (4) drive_cycle(0, 0, 1'b0);
    drive_cycle(0, 0, 1'b1);
    drive_cycle(0, 0, 1'b0);

    if (rec_set_count == 0) begin
      err_count = err_count + 1;
      $display("No status sample reported a blocked interval");
    end
    if (rec_clear_count == 0) begin
      err_count = err_count + 1;
      $display("No status sample reported a clean interval");
    end
    if (release_count == 0) begin
      err_count = err_count + 1;
      $display("Write blocking was never released by a packet end");
    end
    $display("Checks done with %0d error(s)", err_count);
    if (err_count == 0) begin
      $display("Regression passed");
    end else begin
      $display("Regression failed");
    end
    $finish;
  end

  initial begin
    cycle_count = 0;
    while (cycle_count < CYCLE_LIMIT) begin
      @(posedge rd_clk);
      cycle_count = cycle_count + 1;
    end
    $display("Timeout after %0d cycles, the test sequence did not complete", CYCLE_LIMIT);
    $display("Checks done with %0d error(s)", err_count);
    $display("Regression failed");
    $finish;
  end

endmodule

// File: sim.f
+incdir+source
source/dsiq_stream_pkg.sv
source/dsiq_status_pkg.sv
source/dsiq_byte_packer.sv
source/dsiq_word_store.sv
source/dsiq_flow_ctrl.sv
source/dsiq_buffer.sv
dv/dsiq_buffer_tb.sv

// File: run_sim.sh
#!/bin/sh
# builds the dsiq_buffer testbench with Verilator and runs it

cd "$(dirname "$0")" || exit 1

log=sim.log
obj=obj_dir

verilator --binary --timing --assert --timescale 1ns/1ps \
  -f sim.f --top-module dsiq_buffer_tb -Mdir "$obj" -o dsiq_buffer_tb
build_status=$?
if [ $build_status -ne 0 ]; then
  echo "verilator build failed with status $build_status"
  exit 1
fi

"./$obj/dsiq_buffer_tb" > "$log" 2>&1
sim_status=$?
cat "$log"
if [ $sim_status -ne 0 ]; then
  echo "simulation exited with status $sim_status"
  exit 1
fi

if grep -qx "Regression passed" "$log"; then
  echo "result: pass"
  exit 0
fi

echo "result: fail, see $log"
exit 1
